// File: dma_wr_realign.f
verilog/dma_wr_pkg.sv
verilog/dword_bank.sv
verilog/dword_fifo_wr.sv
verilog/realign_ctrl.sv
verilog/qword_pack.sv
verilog/dma_wr_realign_top.sv
sim/tb_dma_wr_realign.sv

// File: sim/tb_dma_wr_realign.sv
// inputs change on the falling edge; init is pulsed only while idle and with no dword offered
module tb_dma_wr_realign;
    import dma_wr_pkg::*;

    localparam int WAIT_LIMIT = 400;    // cycles allowed per wait loop
    localparam int AV_OFF     = 0;
    localparam int AV_ON      = 1;
    localparam int AV_RAND    = 2;

    logic   hclk;
    logic   rst_n;
    logic   init;
    logic   start;
    wcnt_t  wcnt;
    lane_t  woffs;
    dword_t din;
    logic   din_avail;
    logic   din_rdy;
    logic   dout_av;
    qword_t dout;
    wstb_t  dout_wstb;
    logic   dout_we;
    logic   done;

    integer seed = 32'ha812_7b1c;
    word_t  stream [$];                 // accepted words not yet seen at dout
    int     err_count = 0;
    int     chk_count = 0;
    bit     timed_out = 0;
    bit     feed_en = 0;                // offer dwords
    int     av_mode = AV_OFF;           // how dout_av is driven
    bit     acc_seen = 0;               // dword taken at the last rising edge
    int     acc_count = 0;              // dwords since reset or init
    dword_t first_dword;                // first dword after reset or init
    int     xfer_wp = 0;                // lane of the next output word
    int     xfer_left = 0;              // words still owed by this transfer
    int     xfer_qwords = 0;
    bit     xfer_first = 0;
    word_t  first_out_word;             // first strobed word of the transfer

    dma_wr_realign_top dut_i (
        .hclk      (hclk),
        .rst_n     (rst_n),
        .init      (init),
        .start     (start),
        .wcnt      (wcnt),
        .woffs     (woffs),
        .din       (din),
        .din_avail (din_avail),
        .din_rdy   (din_rdy),
        .dout_av   (dout_av),
        .dout      (dout),
        .dout_wstb (dout_wstb),
        .dout_we   (dout_we),
        .done      (done)
    );

    initial begin
        hclk = 1'b0;
        forever #5 hclk = ~hclk;
    end

    task automatic report_fail(input string msg);
        err_count++;
        $display("FAIL t=%0t %s", $time, msg);
    endtask

    task automatic expect_true(input bit ok, input string msg);
        chk_count++;
        assert (ok) else report_fail(msg);
    endtask

    task automatic timeout_hit(input string what);
        timed_out = 1'b1;
        $display("timeout: gave up waiting for %s", what);
    endtask

    // sink must have offered room in the cycle before each write
    we_after_av_a: assert property (@(posedge hclk) disable iff (!rst_n)
                                    dout_we |-> $past(dout_av))
        else report_fail("dout_we without dout_av in the cycle before");
    done_with_we_a: assert property (@(posedge hclk) disable iff (!rst_n) done |-> dout_we)
        else report_fail("done without dout_we");

    // strobes from wp and the words owed, data from the word stream in lane order
    task automatic check_qword();
        int    n;
        int    i;
        wstb_t exp_stb;
        word_t w;
        n = (xfer_left < LANES - xfer_wp) ? xfer_left : LANES - xfer_wp;
        expect_true(xfer_left > 0, "dout_we with no words owed");
        for (i = 0; i < LANES; i++) begin
            exp_stb[i] = (i >= xfer_wp) && (i < xfer_wp + n);
        end
        expect_true(dout_wstb == exp_stb,
                    $sformatf("dout_wstb %b, expected %b", dout_wstb, exp_stb));
        for (i = 0; i < LANES; i++) begin
            if (exp_stb[i]) begin
                if (stream.size() == 0) begin
                    report_fail("strobed lane with no word left in the stream model");
                end else begin
                    w = stream.pop_front();
                    expect_true(dout[WORD_W*i +: WORD_W] == w,
                                $sformatf("lane %0d is %h, expected %h", i,
                                          dout[WORD_W*i +: WORD_W], w));
                    if (xfer_first) begin
                        first_out_word = dout[WORD_W*i +: WORD_W];
                        xfer_first     = 1'b0;
                    end
                end
            end
        end
        xfer_left -= n;
        xfer_wp    = 0;                 // later qwords start at lane 0
        xfer_qwords++;
        expect_true(done == (xfer_left == 0),
                    $sformatf("done %b with %0d words still owed", done, xfer_left));
    endtask

    // word-stream model and output checks
    always @(posedge hclk) begin
        acc_seen = din_avail && din_rdy;
        if (!rst_n || init) begin
            stream.delete();
            acc_count = 0;
            acc_seen  = 1'b0;
        end else begin
            if (dout_we) begin
                check_qword();
            end
            if (acc_seen) begin
                if (acc_count == 0) begin
                    first_dword = din;
                end
                stream.push_back(din[WORD_W-1:0]);       // low half first
                stream.push_back(din[DWORD_W-1:WORD_W]);
                acc_count++;
            end
        end
    end

    // dword source and sink room
    always @(negedge hclk) begin
        if (acc_seen || !din_avail) begin
            din = $random(seed);                          // next dword once taken
        end
        din_avail = feed_en;
        case (av_mode)
            AV_ON:   dout_av = 1'b1;
            AV_RAND: dout_av = 1'($random(seed));
            default: dout_av = 1'b0;
        endcase
    end

    task automatic set_feed(input bit en);
        @(posedge hclk);
        feed_en = en;
    endtask

    task automatic pulse_init();
        @(posedge hclk);
        feed_en = 1'b0;
        av_mode = AV_OFF;
        repeat (2) @(negedge hclk);
        init = 1'b1;
        @(negedge hclk);
        init = 1'b0;
    endtask

    task automatic run_transfer(input int offs, input int nw, input int av);
        int cyc;
        bit finished;
        if (timed_out) return;
        @(posedge hclk);
        av_mode = av;                   // driver takes it at the next falling edge
        @(negedge hclk);
        xfer_wp     = offs;
        xfer_left   = nw;
        xfer_qwords = 0;
        xfer_first  = 1'b1;
        start       = 1'b1;
        wcnt        = wcnt_t'(nw - 1);  // count is 0-based
        woffs       = lane_t'(offs);
        cyc         = 0;
        finished    = 1'b0;
        while (!finished && !timed_out) begin
            @(posedge hclk);
            finished = done;
            @(negedge hclk);
            start = 1'b0;
            cyc++;
            if (!finished && cyc >= WAIT_LIMIT) begin
                timeout_hit($sformatf("done of a %0d word transfer", nw));
            end
        end
        expect_true(xfer_qwords == (offs + nw + LANES - 1) / LANES,
                    $sformatf("%0d qwords for woffs %0d and %0d words", xfer_qwords, offs, nw));
        expect_true(xfer_left == 0, $sformatf("%0d words owed after done", xfer_left));
    endtask

    task automatic run_random(input int av);
        int offs;
        int nw;
        if (timed_out) return;
        @(posedge hclk);
        offs = $unsigned($random(seed)) % LANES;
        nw   = $unsigned($random(seed)) % 24 + 1;
        run_transfer(offs, nw, av);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        $display("test %-24s %0d errors", name, err_count - errs_before);
    endtask

    initial begin
        int errs;
        int cyc;
        rst_n     = 1'b0;
        init      = 1'b0;
        start     = 1'b0;
        wcnt      = '0;
        woffs     = '0;
        din       = '0;
        din_avail = 1'b0;
        dout_av   = 1'b0;
        repeat (4) @(posedge hclk);     // four rising edges in reset
        @(negedge hclk);
        rst_n = 1'b1;

        errs = err_count;
        repeat (3) begin
            @(negedge hclk);
            expect_true(!dout_we && !done, "dout_we or done high after reset");
            expect_true(din_rdy, "din_rdy low with an empty FIFO");
        end
        finish_test("reset state", errs);

        errs = err_count;
        set_feed(1'b1);
        run_transfer(0, 16, AV_ON);
        run_transfer(0, 8, AV_ON);
        run_transfer(0, 4, AV_ON);
        finish_test("aligned", errs);

        errs = err_count;
        repeat (8) run_random(AV_ON);
        finish_test("unaligned back to back", errs);

        errs = err_count;
        repeat (8) run_random(AV_RAND);
        finish_test("random back-pressure", errs);

        // sink stalled and idle, so nothing leaves the FIFO
        errs = err_count;
        pulse_init();
        set_feed(1'b1);
        @(negedge hclk);
        cyc = 0;
        while (din_rdy && !timed_out) begin
            @(negedge hclk);
            cyc++;
            if (din_rdy && cyc >= WAIT_LIMIT) begin
                timeout_hit("din_rdy to drop with the sink stalled");
            end
        end
        expect_true(acc_count == 2 * FIFO_DEPTH,
                    $sformatf("din_rdy dropped after %0d dwords", acc_count));
        repeat (3) begin
            @(negedge hclk);
            expect_true(!din_rdy && acc_count == 2 * FIFO_DEPTH, "dword accepted while full");
        end
        run_transfer(1, 30, AV_ON);
        run_transfer(0, 12, AV_RAND);
        finish_test("full FIFO", errs);

        errs = err_count;
        pulse_init();
        set_feed(1'b1);
        run_transfer(2, 9, AV_ON);
        expect_true(first_out_word == first_dword[WORD_W-1:0],
                    $sformatf("first word %h after init, expected %h",
                              first_out_word, first_dword[WORD_W-1:0]));
        finish_test("init restart", errs);

        $display("tests 6, checks %0d, errors %0d", chk_count, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verilog/dma_wr_realign_top.sv
// single clock; no flush of a trailing odd word, so a partial qword waits for more input
module dma_wr_realign_top (
    input  logic               hclk,
    input  logic               rst_n,
    input  logic               init,        // empty FIFO and restart stream
    input  logic               start,       // honoured while idle
    input  dma_wr_pkg::wcnt_t  wcnt,        // words minus one
    input  dma_wr_pkg::lane_t  woffs,       // first lane
    input  dma_wr_pkg::dword_t din,
    input  logic               din_avail,
    output logic               din_rdy,
    input  logic               dout_av,
    output dma_wr_pkg::qword_t dout,
    output dma_wr_pkg::wstb_t  dout_wstb,
    output logic               dout_we,
    output logic               done
);
    import dma_wr_pkg::*;

    logic [NUM_BANKS-1:0]   bank_we;
    qidx_t                  wr_idx;
    dword_t                 wr_data;
    qptr_t                  wr_qptr;
    qptr_t                  rd_qptr;
    qidx_t                  rd_idx;
    dword_t [NUM_BANKS-1:0] bank_rdata;  // together the head qword
    lane_sel_t [LANES-1:0]  lane_sel;
    wstb_t                  lane_en;
    logic                   step;
    logic                   fifo_rd;

    dword_fifo_wr fifo_wr_i (
        .hclk      (hclk),
        .rst_n     (rst_n),
        .init      (init),
        .din       (din),
        .din_avail (din_avail),
        .din_rdy   (din_rdy),
        .rd_qptr   (rd_qptr),
        .wr_qptr   (wr_qptr),
        .bank_we   (bank_we),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data)
    );

    // bank 0 takes even dwords and bank 1 odd ones
    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
        dword_bank bank_i (
            .hclk    (hclk),
            .we      (bank_we[k]),
            .wr_idx  (wr_idx),
            .wr_data (wr_data),
            .rd_idx  (rd_idx),
            .rd_data (bank_rdata[k])
        );
    end

    realign_ctrl ctrl_i (
        .hclk     (hclk),
        .rst_n    (rst_n),
        .init     (init),
        .start    (start),
        .wcnt     (wcnt),
        .woffs    (woffs),
        .dout_av  (dout_av),
        .wr_qptr  (wr_qptr),
        .rd_qptr  (rd_qptr),
        .rd_idx   (rd_idx),
        .lane_sel (lane_sel),
        .lane_en  (lane_en),
        .step     (step),
        .fifo_rd  (fifo_rd),
        .done     (done)
    );

    qword_pack pack_i (
        .hclk       (hclk),
        .rst_n      (rst_n),
        .init       (init),
        .bank_rdata (bank_rdata),
        .lane_sel   (lane_sel),
        .lane_en    (lane_en),
        .step       (step),
        .fifo_rd    (fifo_rd),
        .dout       (dout),
        .dout_wstb  (dout_wstb),
        .dout_we    (dout_we)
    );

endmodule

// File: verilog/qword_pack.sv
// one register stage after step; dout and dout_wstb hold their value while dout_we is low
module qword_pack (
    input  logic                                          hclk,
    input  logic                                          rst_n,
    input  logic                                          init,
    input  dma_wr_pkg::dword_t [dma_wr_pkg::NUM_BANKS-1:0] bank_rdata,  // head qword
    input  dma_wr_pkg::lane_sel_t [dma_wr_pkg::LANES-1:0] lane_sel,
    input  dma_wr_pkg::wstb_t                             lane_en,
    input  logic                                          step,
    input  logic                                          fifo_rd,
    output dma_wr_pkg::qword_t                            dout,
    output dma_wr_pkg::wstb_t                             dout_wstb,
    output logic                                          dout_we
);
    import dma_wr_pkg::*;

    word_t [LANES-1:0]   head;        // word 0 is the even dword low half
    word_t [LANES-2:0]   prev;        // words 1..3 of the last popped qword
    word_t [2*LANES-2:0] cand;        // held words then head words
    word_t [LANES-1:0]   lane_word;   // selected word per lane

    assign head = bank_rdata;
    assign cand = {head, prev};

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_word[i] = cand[lane_sel[i]];
        end
    end

    // keep the tail of the qword being popped
    always_ff @(posedge hclk) begin
        if (fifo_rd) begin
            prev <= head[LANES-1:1];
        end
    end

    always_ff @(posedge hclk) begin
        if (step) begin
            dout      <= lane_word;
            dout_wstb <= lane_en;     // strobes follow the step table
        end
    end

    always_ff @(posedge hclk) begin
        if (!rst_n || init) begin
            dout_we <= 1'b0;
        end else begin
            dout_we <= step;          // low when no step was taken
        end
    end

endmodule

// File: verilog/realign_ctrl.sv
// start is taken only in ST_IDLE; a step that needs head words waits for a complete qword
module realign_ctrl (
    input  logic                                          hclk,
    input  logic                                          rst_n,
    input  logic                                          init,      // restart the stream
    input  logic                                          start,     // transfer request
    input  dma_wr_pkg::wcnt_t                             wcnt,      // words minus one
    input  dma_wr_pkg::lane_t                             woffs,     // first output lane
    input  logic                                          dout_av,   // sink has room
    input  dma_wr_pkg::qptr_t                             wr_qptr,
    output dma_wr_pkg::qptr_t                             rd_qptr,
    output dma_wr_pkg::qidx_t                             rd_idx,    // head row
    output dma_wr_pkg::lane_sel_t [dma_wr_pkg::LANES-1:0] lane_sel,
    output dma_wr_pkg::wstb_t                             lane_en,   // lanes written
    output logic                                          step,      // emit one qword
    output logic                                          fifo_rd,   // pop the head qword
    output logic                                          done       // with last dout_we
);
    import dma_wr_pkg::*;

    realign_state_e state;
    lane_t          wp;          // output lane of the next word
    lane_t          fp;          // next stream word in candidate space
    wcnt_t          left;        // words remaining minus one
    logic [2:0]     left_cap;    // remaining words up to 4
    logic [2:0]     room;        // lanes from wp to the top
    logic [2:0]     nwords;      // words moved by this step
    logic [2:0]     fp_sum;      // fp plus words moved
    logic           need_rd;     // step reaches into the head qword
    logic           qword_av;    // a complete qword waits
    logic           last;        // step empties the count

    // step table over wp, fp and words left
    always_comb begin
        left_cap = (left > wcnt_t'(LANES - 1)) ? 3'(LANES) : 3'(left[1:0]) + 3'd1;
        room     = 3'(LANES) - {1'b0, wp};
        nwords   = (left_cap < room) ? left_cap : room;
        fp_sum   = {1'b0, fp} + nwords;
        need_rd  = fp_sum[2];                    // crossed into the next qword
        for (int i = 0; i < LANES; i++) begin
            if (3'(i) >= {1'b0, wp}) begin
                lane_sel[i] = {1'b0, fp} + 3'(i) - {1'b0, wp};   // words in lane order
            end else begin
                lane_sel[i] = '0;                // lane below the start offset
            end
            lane_en[i] = (3'(i) >= {1'b0, wp}) && (3'(i) < {1'b0, wp} + nwords);
        end
    end

    assign qword_av = (wr_qptr != rd_qptr);
    assign last     = (left == wcnt_t'(nwords - 3'd1));
    assign step     = (state == ST_RUN) && dout_av && (!need_rd || qword_av);
    assign fifo_rd  = step && need_rd;
    assign rd_idx   = rd_qptr[FIFO_ABITS-1:0];

    always_ff @(posedge hclk) begin
        if (!rst_n || init) begin
            state   <= ST_IDLE;
            wp      <= '0;
            fp      <= lane_t'(LANES - 1);       // next word is head word 0
            left    <= '0;
            rd_qptr <= '0;
            done    <= 1'b0;
        end else begin
            done <= step && last;                // lines up with the packer output
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_RUN;
                        wp    <= woffs;
                        left  <= wcnt;
                    end
                end
                ST_RUN: begin
                    if (step) begin
                        wp   <= '0;              // later qwords start at lane 0
                        fp   <= fp_sum[1:0];
                        left <= left - wcnt_t'(nwords);
                        if (last) begin
                            state <= ST_IDLE;    // leftover words stay queued
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
            if (fifo_rd) begin
                rd_qptr <= rd_qptr + 1'b1;       // frees one row in each bank
            end
        end
    end

endmodule

// File: verilog/dword_fifo_wr.sv
// accepts while not full; space comes back one whole qword at a time as rd_qptr advances
module dword_fifo_wr (
    input  logic                             hclk,
    input  logic                             rst_n,
    input  logic                             init,       // empties the FIFO
    input  dma_wr_pkg::dword_t               din,
    input  logic                             din_avail,
    output logic                             din_rdy,    // FIFO not full
    input  dma_wr_pkg::qptr_t                rd_qptr,    // from the realign side
    output dma_wr_pkg::qptr_t                wr_qptr,    // complete qwords written
    output logic [dma_wr_pkg::NUM_BANKS-1:0] bank_we,
    output dma_wr_pkg::qidx_t                wr_idx,
    output dma_wr_pkg::dword_t               wr_data
);
    import dma_wr_pkg::*;

    logic [FIFO_ABITS+1:0] wptr;        // dword pointer with wrap bit
    qptr_t                 used;        // qwords held against the reader
    logic                  full;
    logic                  accept;      // dword taken this cycle

    assign wr_qptr = wptr[FIFO_ABITS+1:1];
    assign wr_idx  = wptr[FIFO_ABITS:1];   // same row for both banks
    assign wr_data = din;
    assign used    = wr_qptr - rd_qptr;
    assign full    = (used == qptr_t'(FIFO_DEPTH));   // 16 dwords outstanding
    assign din_rdy = !full;
    assign accept  = din_avail && din_rdy;

    // low pointer bit selects the bank
    always_comb begin
        for (int k = 0; k < NUM_BANKS; k++) begin
            bank_we[k] = accept && (wptr[0] == 1'(k));
        end
    end

    always_ff @(posedge hclk) begin
        if (!rst_n || init) begin
            wptr <= '0;
        end else if (accept) begin
            wptr <= wptr + 1'b1;              // write and advance on the same edge
        end
    end

endmodule

// File: verilog/dword_bank.sv
// storage only with no reset; read is combinational so data follows rd_idx in the same cycle
module dword_bank (
    input  logic               hclk,
    input  logic               we,       // write this bank
    input  dma_wr_pkg::qidx_t  wr_idx,   // row to write
    input  dma_wr_pkg::dword_t wr_data,
    input  dma_wr_pkg::qidx_t  rd_idx,   // head row
    output dma_wr_pkg::dword_t rd_data   // async read
);
    import dma_wr_pkg::*;

    dword_t mem [FIFO_DEPTH];            // one dword per qword row

    always_ff @(posedge hclk) begin
        if (we) begin
            mem[wr_idx] <= wr_data;
        end
    end

    assign rd_data = mem[rd_idx];        // no output register

endmodule

// File: verilog/dma_wr_pkg.sv
// single hclk domain; 16-bit words, 8-qword FIFO, word count 0-based and 21 bits wide
package dma_wr_pkg;

    localparam int WORD_W     = 16;                 // realign granule
    localparam int DWORD_W    = 32;                 // input beat
    localparam int QWORD_W    = 64;                 // output beat
    localparam int LANES      = QWORD_W / WORD_W;   // words per qword
    localparam int NUM_BANKS  = QWORD_W / DWORD_W;  // even and odd dword banks
    localparam int FIFO_ABITS = 3;                  // qword row index bits
    localparam int FIFO_DEPTH = 1 << FIFO_ABITS;    // rows per bank
    localparam int WCNT_BITS  = 21;                 // transfer word count

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [DWORD_W-1:0]   dword_t;
    typedef logic [QWORD_W-1:0]   qword_t;
    typedef logic [LANES-1:0]     wstb_t;           // one strobe per word lane
    typedef logic [WCNT_BITS-1:0] wcnt_t;
    typedef logic [1:0]           lane_t;           // lane or word offset
    typedef logic [FIFO_ABITS-1:0] qidx_t;          // bank row
    typedef logic [FIFO_ABITS:0]  qptr_t;           // row plus wrap bit

    // candidate word for a lane
    // held words 1..3 sit at 0..2 and head qword words 0..3 at 3..6
    typedef logic [2:0] lane_sel_t;

    typedef enum logic {
        ST_IDLE,                                    // waiting for start
        ST_RUN                                      // emitting qwords
    } realign_state_e;

endpackage
